//--- project.f
+incdir+bench
design/blit_fifo_pkg.sv
design/blit_fifo_level.sv
design/blit_enqueue_unpack.sv
design/blit_pixel_ring.sv
design/blit_dequeue_pack.sv
design/blit_fifo.sv
bench/blit_fifo_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the blit FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f project.f --top-module blit_fifo_tb \
    --Mdir obj_dir -o blit_fifo_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed"
    exit "$status"
fi

./obj_dir/blit_fifo_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit "$status"
fi

exit 0

//--- bench/blit_fifo_model.svh
`ifndef BLIT_FIFO_MODEL_SVH
`define BLIT_FIFO_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// Ring model, slots wide enough for either pixel size
logic [15:0] model_slots [8];
int          model_wr;
int          model_rd;
int          model_level;

function automatic int mode_depth(input color_mode_t mode);
    return (mode == MODE_16BPP) ? DEPTH_16 : DEPTH_8;
endfunction

function automatic int pixel_bits(input color_mode_t mode);
    return (mode == MODE_16BPP) ? 16 : 8;
endfunction

// Lane i of a pop is the slot i places past the read pointer, lane 0 on top
function automatic word_t expected_word(input color_mode_t mode);
    word_t word;
    int    width;
    int    slot;
    width = pixel_bits(mode);
    word  = '0;
    for (int i = 0; i < 32 / width; i++) begin
        slot = (model_rd + i) % mode_depth(mode);
        for (int b = 0; b < width; b++) begin
            word[31 - i * width - b] = model_slots[slot][width - 1 - b];
        end
    end
    return word;
endfunction

// Bits covered by the lanes below the pop count
function automatic word_t lane_mask(input color_mode_t mode, input int count);
    word_t mask;
    mask = '0;
    for (int b = 0; b < count * pixel_bits(mode); b++) begin
        mask[31 - b] = 1'b1;
    end
    return mask;
endfunction

task automatic model_push(input color_mode_t mode, input int count, input word_t data);
    int width;
    int slot;
    width = pixel_bits(mode);
    for (int i = 0; i < count; i++) begin
        slot = (model_wr + i) % mode_depth(mode);
        model_slots[slot] = '0;
        for (int b = 0; b < width; b++) begin
            model_slots[slot][width - 1 - b] = data[31 - i * width - b];
        end
    end
    model_wr    = (model_wr + count) % mode_depth(mode);
    model_level = model_level + count;
endtask

task automatic model_pop(input color_mode_t mode, input int count);
    model_rd    = (model_rd + count) % mode_depth(mode);
    model_level = model_level - count;
endtask

task automatic model_clear();
    model_wr    = 0;
    model_rd    = 0;
    model_level = 0;
endtask

`endif

//--- bench/blit_fifo_tb.sv
module blit_fifo_tb import blit_fifo_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int RANDOM_OPS   = 240;
    localparam int DIRECTED_OPS = 64;
    localparam int PLANNED_OPS  = RESET_CYCLES + 2 * RANDOM_OPS + DIRECTED_OPS;

    logic        CLK;
    logic        RESET_n;
    logic        clk_en;
    color_mode_t color_mode;
    logic        clear;
    logic        enqueue;
    count_t      enqueue_count;
    word_t       enqueue_data;
    logic        dequeue;
    count_t      dequeue_count;
    word_t       dequeue_data8;
    word_t       dequeue_data16;
    level_t      avail_count;
    level_t      free_count;

    logic [31:0] lfsr_state = 32'hea20_d208;
    logic        checking = 1'b0;
    int          last_push;

    // Expected effect of the coming edge for the compare process
    logic        pend_pop;
    word_t       pend_word;
    word_t       pend_mask;
    color_mode_t pend_mode;
    logic        pend_clear;
    int          pend_level;

    `include "blit_fifo_model.svh"

    blit_fifo dut (.*);

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    initial begin : watchdog
        #(PLANNED_OPS * 10 * CLK_PERIOD);
        $display(">>> FAIL");
        $fatal(1, "Timeout, the tests did not finish within %0d cycles", PLANNED_OPS * 10);
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0d ns, %s: got 0x%h, expected 0x%h",
                     $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "%s differs from the model", name);
        end
    endtask

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // One clock of stimulus and the model update for the next edge
    task automatic drive_cycle(input logic en, input logic clr, input color_mode_t mode,
                               input logic enq, input int ecnt, input logic deq, input int dcnt);
        logic [31:0] data;
        @(negedge CLK);
        draw_bits(32, data);
        clk_en        = en;
        clear         = clr;
        color_mode    = mode;
        enqueue       = enq;
        enqueue_count = count_t'(ecnt);
        enqueue_data  = data;
        dequeue       = deq;
        dequeue_count = count_t'(dcnt);
        pend_pop      = 1'b0;
        pend_word     = '0;
        pend_mask     = '0;
        if (clr) begin
            model_clear();
            last_push = 0;
        end else if (en) begin
            // Pixels pushed on the previous edge are not in the ring yet
            if ((deq && dcnt > model_level - last_push) ||
                (enq && ecnt > mode_depth(mode) - model_level + (deq ? dcnt : 0))) begin
                $display(">>> FAIL");
                $fatal(1, "Stimulus would overflow or underflow the FIFO");
            end
            if (deq) begin
                pend_pop  = 1'b1;
                pend_word = expected_word(mode);
                pend_mask = lane_mask(mode, dcnt);
                model_pop(mode, dcnt);
            end
            if (enq) begin
                model_push(mode, ecnt, data);
            end
            last_push = enq ? ecnt : 0;
        end else begin
            last_push = 0;
        end
        pend_mode  = mode;
        pend_clear = clr;
        pend_level = model_level;
    endtask

    task automatic idle_cycles(input color_mode_t mode, input int cycles);
        repeat (cycles) begin
            drive_cycle(1'b1, 1'b0, mode, 1'b0, 0, 1'b0, 0);
        end
    endtask

    // Random counts trimmed to what the model can take
    task automatic random_cycle(input color_mode_t mode, input int max_count);
        logic [31:0] r_en;
        logic [31:0] r_enq;
        logic [31:0] r_deq;
        int          ecnt;
        int          dcnt;
        int          space;
        draw_bits(3, r_en);
        draw_bits(4, r_enq);
        draw_bits(4, r_deq);
        ecnt = int'(r_enq[2:0]) % (max_count + 1);
        dcnt = int'(r_deq[2:0]) % (max_count + 1);
        if (dcnt > model_level - last_push) begin
            dcnt = model_level - last_push;
        end
        space = mode_depth(mode) - model_level + (r_deq[3] ? dcnt : 0);
        if (ecnt > space) begin
            ecnt = space;
        end
        drive_cycle(r_en != 0, 1'b0, mode, r_enq[3], ecnt, r_deq[3], dcnt);
    endtask

    initial begin : compare
        logic        pop;
        word_t       word;
        word_t       mask;
        color_mode_t mode;
        logic        clr;
        int          level;
        int          prev_level;
        word_t       held8;
        word_t       held16;
        prev_level = 0;
        held8      = '0;
        held16     = '0;
        forever begin
            @(posedge CLK);
            if (checking) begin
                pop   = pend_pop;
                word  = pend_word;
                mask  = pend_mask;
                mode  = pend_mode;
                clr   = pend_clear;
                level = pend_level;
                @(negedge CLK);
                if (pop && mode == MODE_8BPP) begin
                    check_value("dequeue_data8", dequeue_data8 & mask, word & mask);
                end else if (pop) begin
                    check_value("dequeue_data16", dequeue_data16 & mask, word & mask);
                end else begin
                    // Both words hold without a pop
                    check_value("dequeue_data8", dequeue_data8, held8);
                    check_value("dequeue_data16", dequeue_data16, held16);
                end
                held8  = dequeue_data8;
                held16 = dequeue_data16;
                check_value("avail_count", 32'(avail_count), level);
                // free_count trails avail_count by one edge
                check_value("free_count", 32'(free_count),
                            clr ? 0 : mode_depth(mode) - prev_level);
                prev_level = level;
            end
        end
    end

    initial begin : stimulus
        clk_en        = 1'b1;
        color_mode    = MODE_8BPP;
        clear         = 1'b0;
        enqueue       = 1'b0;
        enqueue_count = '0;
        enqueue_data  = '0;
        dequeue       = 1'b0;
        dequeue_count = '0;
        RESET_n       = 1'b0;
        pend_pop      = 1'b0;
        pend_word     = '0;
        pend_mask     = '0;
        pend_mode     = MODE_8BPP;
        pend_clear    = 1'b0;
        pend_level    = 0;
        last_push     = 0;
        model_clear();

        repeat (RESET_CYCLES) @(negedge CLK);
        check_value("dequeue_data8", dequeue_data8, 0);
        check_value("dequeue_data16", dequeue_data16, 0);
        check_value("avail_count", 32'(avail_count), 0);
        check_value("free_count", 32'(free_count), 0);
        RESET_n  = 1'b1;
        checking = 1'b1;

        // Random 8 bpp stream with wraps and same cycle push and pop
        repeat (RANDOM_OPS) begin
            random_cycle(MODE_8BPP, 4);
        end

        // Strobes with the clock enable low, counts that do not cancel
        repeat (3) begin
            drive_cycle(1'b0, 1'b0, MODE_8BPP, 1'b1, 4, 1'b1, 1);
        end
        idle_cycles(MODE_8BPP, 2);

        // Clear with pixels held and refill from lane position 0
        drive_cycle(1'b1, 1'b1, MODE_8BPP, 1'b0, 0, 1'b0, 0);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b1, 2, 1'b0, 0);
        idle_cycles(MODE_8BPP, 1);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b0, 0, 1'b1, 2);

        // Fill to the depth and push into the slots a pop frees
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b1, 3, 1'b0, 0);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b1, 4, 1'b0, 0);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b1, 1, 1'b0, 0);
        idle_cycles(MODE_8BPP, 1);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b1, 3, 1'b1, 3);
        idle_cycles(MODE_8BPP, 1);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b0, 0, 1'b1, 4);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b1, 2, 1'b1, 4);
        idle_cycles(MODE_8BPP, 1);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b0, 0, 1'b1, 2);
        drive_cycle(1'b1, 1'b0, MODE_8BPP, 1'b0, 0, 1'b1, 0);

        // Mode switch right after a clear
        idle_cycles(MODE_8BPP, 1);
        drive_cycle(1'b1, 1'b1, MODE_8BPP, 1'b0, 0, 1'b0, 0);
        idle_cycles(MODE_16BPP, 2);
        repeat (RANDOM_OPS) begin
            random_cycle(MODE_16BPP, 2);
        end

        // Full 16 bpp ring and wrap
        idle_cycles(MODE_16BPP, 1);
        drive_cycle(1'b1, 1'b1, MODE_16BPP, 1'b0, 0, 1'b0, 0);
        drive_cycle(1'b1, 1'b0, MODE_16BPP, 1'b1, 2, 1'b0, 0);
        drive_cycle(1'b1, 1'b0, MODE_16BPP, 1'b1, 2, 1'b0, 0);
        idle_cycles(MODE_16BPP, 1);
        drive_cycle(1'b1, 1'b0, MODE_16BPP, 1'b1, 1, 1'b1, 1);
        idle_cycles(MODE_16BPP, 1);
        drive_cycle(1'b1, 1'b0, MODE_16BPP, 1'b0, 0, 1'b1, 2);
        drive_cycle(1'b1, 1'b0, MODE_16BPP, 1'b0, 0, 1'b1, 2);
        idle_cycles(MODE_16BPP, 3);

        repeat (2) @(posedge CLK);
        #1;
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- design/blit_fifo.sv
module blit_fifo import blit_fifo_pkg::*; #(
    parameter int DEPTH8  = DEPTH_8,
    parameter int DEPTH16 = DEPTH_16
) (
    input  logic        CLK,
    input  logic        RESET_n,
    input  logic        clk_en,
    input  color_mode_t color_mode,
    input  logic        clear,
    input  logic        enqueue,
    input  count_t      enqueue_count,
    input  word_t       enqueue_data,
    input  logic        dequeue,
    input  count_t      dequeue_count,
    output word_t       dequeue_data8,
    output word_t       dequeue_data16,
    output level_t      avail_count,
    output level_t      free_count
);

    localparam int LANES8   = $bits(word_t) / $bits(pix8_t);
    localparam int LANES16  = $bits(word_t) / $bits(pix16_t);
    localparam int SLOT8_W  = $clog2(DEPTH8);
    localparam int SLOT16_W = $clog2(DEPTH16);

    logic                enq_take;
    logic                deq_take;
    logic                write_strobe;
    count_t              write_count;
    logic [LANES8-1:0]   lane_en;
    pix8_t               lanes8 [LANES8];
    pix16_t              lanes16 [LANES16];
    logic [SLOT8_W-1:0]  read_slot8 [LANES8];
    logic [SLOT16_W-1:0] read_slot16 [LANES16];
    pix8_t               read_pixel8 [LANES8];
    pix16_t              read_pixel16 [LANES16];

    blit_fifo_level #(
        .DEPTH8  (DEPTH8),
        .DEPTH16 (DEPTH16)
    ) u_level (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .clk_en        (clk_en),
        .clear         (clear),
        .color_mode    (color_mode),
        .enqueue       (enqueue),
        .enqueue_count (enqueue_count),
        .dequeue       (dequeue),
        .dequeue_count (dequeue_count),
        .enq_take      (enq_take),
        .deq_take      (deq_take),
        .avail_count   (avail_count),
        .free_count    (free_count)
    );

    blit_enqueue_unpack u_unpack (
        .CLK           (CLK),
        .RESET_n       (RESET_n),
        .enq_take      (enq_take),
        .enqueue_count (enqueue_count),
        .enqueue_data  (enqueue_data),
        .write_strobe  (write_strobe),
        .write_count   (write_count),
        .lane_en       (lane_en),
        .lanes8        (lanes8),
        .lanes16       (lanes16)
    );

    blit_pixel_ring #(
        .pixel_t (pix8_t),
        .DEPTH   (DEPTH8)
    ) u_ring8 (
        .CLK          (CLK),
        .RESET_n      (RESET_n),
        .clear        (clear),
        .write_strobe (write_strobe),
        .write_count  (write_count),
        .lane_en      (lane_en),
        .lanes        (lanes8),
        .read_slot    (read_slot8),
        .read_pixel   (read_pixel8)
    );

    // 16 bpp ring only sees the two upper lane enables
    blit_pixel_ring #(
        .pixel_t (pix16_t),
        .DEPTH   (DEPTH16)
    ) u_ring16 (
        .CLK          (CLK),
        .RESET_n      (RESET_n),
        .clear        (clear),
        .write_strobe (write_strobe),
        .write_count  (write_count),
        .lane_en      (lane_en[LANES16-1:0]),
        .lanes        (lanes16),
        .read_slot    (read_slot16),
        .read_pixel   (read_pixel16)
    );

    blit_dequeue_pack #(
        .DEPTH8  (DEPTH8),
        .DEPTH16 (DEPTH16)
    ) u_pack (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .clear          (clear),
        .deq_take       (deq_take),
        .dequeue_count  (dequeue_count),
        .read_pixel8    (read_pixel8),
        .read_pixel16   (read_pixel16),
        .read_slot8     (read_slot8),
        .read_slot16    (read_slot16),
        .dequeue_data8  (dequeue_data8),
        .dequeue_data16 (dequeue_data16)
    );

endmodule

//--- design/blit_dequeue_pack.sv
module blit_dequeue_pack import blit_fifo_pkg::*; #(
    parameter int  DEPTH8   = DEPTH_8,
    parameter int  DEPTH16  = DEPTH_16,
    localparam int LANES8   = $bits(word_t) / $bits(pix8_t),
    localparam int LANES16  = $bits(word_t) / $bits(pix16_t),
    localparam int SLOT8_W  = $clog2(DEPTH8),
    localparam int SLOT16_W = $clog2(DEPTH16)
) (
    input  logic                CLK,
    input  logic                RESET_n,
    input  logic                clear,
    input  logic                deq_take,
    input  count_t              dequeue_count,
    input  pix8_t               read_pixel8 [LANES8],
    input  pix16_t              read_pixel16 [LANES16],
    output logic [SLOT8_W-1:0]  read_slot8 [LANES8],
    output logic [SLOT16_W-1:0] read_slot16 [LANES16],
    output word_t               dequeue_data8,
    output word_t               dequeue_data16
);

    localparam int P8_W  = $bits(pix8_t);
    localparam int P16_W = $bits(pix16_t);
    localparam int TOP   = $bits(word_t) - 1;

    logic [SLOT8_W-1:0]  step8;
    logic [SLOT16_W-1:0] step16;

    // Power of two depths, truncation wraps the step
    assign step8  = dequeue_count[SLOT8_W-1:0];
    assign step16 = dequeue_count[SLOT16_W-1:0];

    // Read offsets double as the slot addresses into the rings
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < LANES8; i++) begin
                read_slot8[i] <= SLOT8_W'(i);
            end
            for (int i = 0; i < LANES16; i++) begin
                read_slot16[i] <= SLOT16_W'(i);
            end
        end else if (clear) begin
            for (int i = 0; i < LANES8; i++) begin
                read_slot8[i] <= SLOT8_W'(i);
            end
            for (int i = 0; i < LANES16; i++) begin
                read_slot16[i] <= SLOT16_W'(i);
            end
        end else if (deq_take) begin
            for (int i = 0; i < LANES8; i++) begin
                read_slot8[i] <= read_slot8[i] + step8;
            end
            for (int i = 0; i < LANES16; i++) begin
                read_slot16[i] <= read_slot16[i] + step16;
            end
        end
    end

    // Both words are packed on every pop; the mode picks which one matters
    // Clear leaves them alone
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            dequeue_data8  <= '0;
            dequeue_data16 <= '0;
        end else if (deq_take) begin
            for (int i = 0; i < LANES8; i++) begin
                dequeue_data8[TOP - i * P8_W -: P8_W] <= read_pixel8[i];
            end
            for (int i = 0; i < LANES16; i++) begin
                dequeue_data16[TOP - i * P16_W -: P16_W] <= read_pixel16[i];
            end
        end
    end

endmodule

//--- design/blit_pixel_ring.sv
module blit_pixel_ring import blit_fifo_pkg::*; #(
    parameter type pixel_t = pix8_t,
    parameter int  DEPTH   = DEPTH_8,
    localparam int LANES   = $bits(word_t) / $bits(pixel_t),
    localparam int SLOT_W  = $clog2(DEPTH)
) (
    input  logic              CLK,
    input  logic              RESET_n,
    input  logic              clear,
    input  logic              write_strobe,
    input  count_t            write_count,
    input  logic [LANES-1:0]  lane_en,
    input  pixel_t            lanes [LANES],
    input  logic [SLOT_W-1:0] read_slot [LANES],
    output pixel_t            read_pixel [LANES]
);

    pixel_t            slots [DEPTH];
    logic [SLOT_W-1:0] wr_off [LANES];
    logic [SLOT_W-1:0] step;

    // Depth is a power of two, so the truncated count is the step mod DEPTH
    assign step = write_count[SLOT_W-1:0];

    // One write offset per lane, spaced by the lane number
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < LANES; i++) begin
                wr_off[i] <= SLOT_W'(i);
            end
        end else if (clear) begin
            for (int i = 0; i < LANES; i++) begin
                wr_off[i] <= SLOT_W'(i);
            end
        end else if (write_strobe) begin
            for (int i = 0; i < LANES; i++) begin
                wr_off[i] <= wr_off[i] + step;
            end
        end
    end

    // Enabled lanes land in distinct slots, offsets never collide
    always_ff @(posedge CLK) begin
        for (int i = 0; i < LANES; i++) begin
            if (lane_en[i]) begin
                slots[wr_off[i]] <= lanes[i];
            end
        end
    end

    // Read side is plain muxing
    for (genvar g = 0; g < LANES; g++) begin : g_read
        assign read_pixel[g] = slots[read_slot[g]];
    end

endmodule

//--- design/blit_enqueue_unpack.sv
module blit_enqueue_unpack import blit_fifo_pkg::*; #(
    localparam int LANES8  = $bits(word_t) / $bits(pix8_t),
    localparam int LANES16 = $bits(word_t) / $bits(pix16_t)
) (
    input  logic              CLK,
    input  logic              RESET_n,
    input  logic              enq_take,
    input  count_t            enqueue_count,
    input  word_t             enqueue_data,
    output logic              write_strobe,
    output count_t            write_count,
    output logic [LANES8-1:0] lane_en,
    output pix8_t             lanes8 [LANES8],
    output pix16_t            lanes16 [LANES16]
);

    word_t word_q;

    // Word is captured with the strobe
    always_ff @(posedge CLK) begin
        if (enq_take) begin
            word_q <= enqueue_data;
        end
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            write_strobe <= 1'b0;
            write_count  <= '0;
        end else begin
            write_strobe <= enq_take;
            if (enq_take) begin
                write_count <= enqueue_count;
            end
        end
    end

    // Lane i carries a pixel only when it is below the count
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            lane_en <= '0;
        end else begin
            for (int i = 0; i < LANES8; i++) begin
                lane_en[i] <= enq_take && (enqueue_count > count_t'(i));
            end
        end
    end

    // Lane 0 is the most significant slice of the word
    for (genvar g = 0; g < LANES8; g++) begin : g_lane8
        assign lanes8[g] = word_q[$bits(word_t) - 1 - g * $bits(pix8_t) -: $bits(pix8_t)];
    end

    for (genvar g = 0; g < LANES16; g++) begin : g_lane16
        assign lanes16[g] = word_q[$bits(word_t) - 1 - g * $bits(pix16_t) -: $bits(pix16_t)];
    end

endmodule

//--- design/blit_fifo_level.sv
module blit_fifo_level import blit_fifo_pkg::*; #(
    parameter int DEPTH8  = DEPTH_8,
    parameter int DEPTH16 = DEPTH_16
) (
    input  logic        CLK,
    input  logic        RESET_n,
    input  logic        clk_en,
    input  logic        clear,
    input  color_mode_t color_mode,
    input  logic        enqueue,
    input  count_t      enqueue_count,
    input  logic        dequeue,
    input  count_t      dequeue_count,
    output logic        enq_take,
    output logic        deq_take,
    output level_t      avail_count,
    output level_t      free_count
);

    count_t enq_add;
    count_t deq_sub;
    level_t depth_sel;

    // Strobes only count while the clock enable is high
    assign enq_take = enqueue && clk_en;
    assign deq_take = dequeue && clk_en;

    assign enq_add = enq_take ? enqueue_count : '0;
    assign deq_sub = deq_take ? dequeue_count : '0;

    assign depth_sel = (color_mode == MODE_16BPP) ? level_t'(DEPTH16) : level_t'(DEPTH8);

    // Pixels held, moves on the strobe edge
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            avail_count <= '0;
        end else if (clear) begin
            avail_count <= '0;
        end else begin
            avail_count <= avail_count + level_t'(enq_add) - level_t'(deq_sub);
        end
    end

    // Free space trails the held count by one edge
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            free_count <= '0;
        end else if (clear) begin
            free_count <= '0;
        end else begin
            free_count <= depth_sel - avail_count;
        end
    end

endmodule

//--- design/blit_fifo_pkg.sv
package blit_fifo_pkg;

    // One pushed or popped bus word
    typedef logic [31:0] word_t;

    // Pixel formats held in the rings
    typedef logic [7:0]  pix8_t;
    typedef logic [15:0] pix16_t;

    // Pixels moved by one push or pop, 0 to 4
    typedef logic [2:0] count_t;

    // Pixels held or free, 0 to 8
    typedef logic [3:0] level_t;

    // Color mode of the blitter
    typedef enum logic {
        MODE_8BPP  = 1'b0,
        MODE_16BPP = 1'b1
    } color_mode_t;

    // Ring depths in pixels, both powers of two
    localparam int DEPTH_8  = 8;
    localparam int DEPTH_16 = 4;

endpackage
